/* design/rv_ctrl_pkg.sv */
`include "rv_decode_cfg.svh"

package rv_ctrl_pkg;

    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_AND  = 4'd2,
        ALU_OR   = 4'd3,
        ALU_XOR  = 4'd4,
        ALU_SLT  = 4'd5,
        ALU_SLTU = 4'd6,
        ALU_SLL  = 4'd7,
        ALU_SRL  = 4'd8,
        ALU_SRA  = 4'd9,
        ALU_MUL  = 4'd10,
        ALU_DIV  = 4'd11,
        ALU_DIVU = 4'd12,
        ALU_REM  = 4'd13,
        ALU_REMU = 4'd14
    } alu_op_e;

    // operand pair fed to the alu
    typedef enum logic [1:0] {
        SRC_REG     = 2'd0, // rs1, rs2
        SRC_IMM     = 2'd1, // rs1, imm
        SRC_PC_IMM  = 2'd2, // pc, imm
        SRC_PC_FOUR = 2'd3  // pc, 4
    } alu_src_e;

    typedef enum logic [2:0] {
        IMM_NONE  = 3'd0,
        IMM_I     = 3'd1,
        IMM_S     = 3'd2,
        IMM_B     = 3'd3,
        IMM_U     = 3'd4,
        IMM_J     = 3'd5,
        IMM_SHAMT = 3'd6
    } imm_kind_e;

    typedef enum logic [2:0] {
        BR_EQ  = 3'd0,
        BR_NE  = 3'd1,
        BR_LT  = 3'd2,
        BR_GE  = 3'd3,
        BR_LTU = 3'd4,
        BR_GEU = 3'd5
    } br_cond_e;

    // same order as funct3[1:0] of loads and stores
    typedef enum logic [1:0] {
        MEM_B = 2'd0,
        MEM_H = 2'd1,
        MEM_W = 2'd2,
        MEM_D = 2'd3
    } mem_size_e;

    typedef struct packed {
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic                  reg_wen;
        logic                  rs1_used;
        logic                  rs2_used;
        alu_op_e               alu_op;
        alu_src_e              alu_src;
        logic                  word_op;  // 32-bit op, result sign-extended
        logic                  mem_read;
        logic                  mem_write;
        mem_size_e             mem_size;
        logic                  mem_unsigned;
        logic                  branch;
        br_cond_e              br_cond;
        logic                  jump;
        logic                  jalr;
    } dec_ctrl_t;

endpackage

/* design/rv_ctrl_stage.sv */
`include "rv_decode_cfg.svh"

module rv_ctrl_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   f_valid,
    input  rv_isa_pkg::rv_fields_t f_fields,
    output logic                   c_valid,
    output rv_isa_pkg::rv_fields_t c_fields,
    output rv_ctrl_pkg::dec_ctrl_t c_ctrl,
    output rv_ctrl_pkg::imm_kind_e c_imm_kind,
    output logic                   c_illegal,
    output logic                   c_ebreak
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    dec_ctrl_t  ctrl_d;
    imm_kind_e  kind_d;
    logic       legal;
    logic       ebreak_d;
    logic       is_word;
    logic [6:0] sh_f7;
    logic [2:0] f3;
    logic [6:0] f7;

    // funct7 == 0 flavour of the integer ops
    function automatic alu_op_e alu_base(input logic [2:0] fn3);
        case (fn3)
            F3_ADD:  return ALU_ADD;
            F3_SLL:  return ALU_SLL;
            F3_SLT:  return ALU_SLT;
            F3_SLTU: return ALU_SLTU;
            F3_XOR:  return ALU_XOR;
            F3_SR:   return ALU_SRL;
            F3_OR:   return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign f3      = f_fields.funct3;
    assign f7      = f_fields.funct7;
    assign is_word = (f_fields.opcode == OPC_OP_32) || (f_fields.opcode == OPC_OP_IMM_32);
    // rv64 slli/srli/srai keep shamt[5] in funct7 bit 0
    assign sh_f7   = is_word ? f7 : {f7[6:1], 1'b0};

    always_comb begin
        ctrl_d     = '0;
        ctrl_d.rd  = f_fields.rd;
        ctrl_d.rs1 = f_fields.rs1;
        ctrl_d.rs2 = f_fields.rs2;
        kind_d     = IMM_NONE;
        legal      = 1'b1;
        ebreak_d   = 1'b0;
        case (f_fields.opcode)
            OPC_OP, OPC_OP_32: begin
                ctrl_d.reg_wen  = 1'b1;
                ctrl_d.rs1_used = 1'b1;
                ctrl_d.rs2_used = 1'b1;
                ctrl_d.alu_src  = SRC_REG;
                ctrl_d.word_op  = is_word;
                ctrl_d.alu_op   = alu_base(f3);
                case (f7)
                    7'd0: begin
                        if (is_word && f3 != F3_ADD && f3 != F3_SLL && f3 != F3_SR) begin
                            legal = 1'b0;
                        end
                    end
                    7'd32: begin
                        if (f3 == F3_ADD) ctrl_d.alu_op = ALU_SUB;
                        else if (f3 == F3_SR) ctrl_d.alu_op = ALU_SRA;
                        else legal = 1'b0;
                    end
                    7'd1: begin
                        case (f3)
                            F3_MUL:  ctrl_d.alu_op = ALU_MUL;
                            F3_DIV:  ctrl_d.alu_op = ALU_DIV;
                            F3_DIVU: ctrl_d.alu_op = ALU_DIVU;
                            F3_REM:  ctrl_d.alu_op = ALU_REM;
                            F3_REMU: ctrl_d.alu_op = ALU_REMU;
                            default: legal = 1'b0; // mulh family
                        endcase
                    end
                    default: legal = 1'b0;
                endcase
            end
            OPC_OP_IMM, OPC_OP_IMM_32: begin
                ctrl_d.reg_wen  = 1'b1;
                ctrl_d.rs1_used = 1'b1;
                ctrl_d.alu_src  = SRC_IMM;
                ctrl_d.word_op  = is_word;
                ctrl_d.alu_op   = alu_base(f3);
                kind_d          = IMM_I;
                if (f3 == F3_SLL || f3 == F3_SR) begin
                    kind_d = IMM_SHAMT;
                    if (f3 == F3_SR && sh_f7 == 7'd32) ctrl_d.alu_op = ALU_SRA;
                    else if (sh_f7 != 7'd0) legal = 1'b0;
                end else if (is_word && f3 != F3_ADD) begin
                    legal = 1'b0;
                end
            end
            OPC_LOAD: begin
                ctrl_d.reg_wen      = 1'b1;
                ctrl_d.rs1_used     = 1'b1;
                ctrl_d.alu_src      = SRC_IMM;
                ctrl_d.mem_read     = 1'b1;
                ctrl_d.mem_size     = mem_size_e'(f3[1:0]);
                ctrl_d.mem_unsigned = f3[2];
                kind_d              = IMM_I;
                legal               = (f3 != 3'd7); // no ldu
            end
            OPC_STORE: begin
                ctrl_d.rs1_used  = 1'b1;
                ctrl_d.rs2_used  = 1'b1;
                ctrl_d.alu_src   = SRC_IMM;
                ctrl_d.mem_write = 1'b1;
                ctrl_d.mem_size  = mem_size_e'(f3[1:0]);
                kind_d           = IMM_S;
                legal            = !f3[2];
            end
            OPC_BRANCH: begin
                ctrl_d.rs1_used = 1'b1;
                ctrl_d.rs2_used = 1'b1;
                ctrl_d.alu_src  = SRC_PC_IMM; // branch target
                ctrl_d.branch   = 1'b1;
                kind_d          = IMM_B;
                case (f3)
                    F3_BEQ:  ctrl_d.br_cond = BR_EQ;
                    F3_BNE:  ctrl_d.br_cond = BR_NE;
                    F3_BLT:  ctrl_d.br_cond = BR_LT;
                    F3_BGE:  ctrl_d.br_cond = BR_GE;
                    F3_BLTU: ctrl_d.br_cond = BR_LTU;
                    F3_BGEU: ctrl_d.br_cond = BR_GEU;
                    default: legal = 1'b0;
                endcase
            end
            OPC_JAL: begin
                ctrl_d.reg_wen = 1'b1;
                ctrl_d.alu_src = SRC_PC_FOUR; // link value
                ctrl_d.jump    = 1'b1;
                kind_d         = IMM_J;
            end
            OPC_JALR: begin
                ctrl_d.reg_wen  = 1'b1;
                ctrl_d.rs1_used = 1'b1;
                ctrl_d.alu_src  = SRC_PC_FOUR;
                ctrl_d.jump     = 1'b1;
                ctrl_d.jalr     = 1'b1;
                kind_d          = IMM_I;
                legal           = (f3 == 3'd0);
            end
            OPC_LUI: begin
                ctrl_d.reg_wen = 1'b1;
                ctrl_d.rs1     = '0; // x0 + imm
                ctrl_d.alu_src = SRC_IMM;
                kind_d         = IMM_U;
            end
            OPC_AUIPC: begin
                ctrl_d.reg_wen = 1'b1;
                ctrl_d.alu_src = SRC_PC_IMM;
                kind_d         = IMM_U;
            end
            OPC_SYSTEM: begin
                ebreak_d = (f_fields.raw == `RV_EBREAK_WORD);
                legal    = ebreak_d;
            end
            default: legal = 1'b0;
        endcase
        // illegal and ebreak both leave an all-zero control word
        if (!legal || ebreak_d) begin
            ctrl_d = '0;
            kind_d = IMM_NONE;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            c_valid   <= 1'b0;
            c_illegal <= 1'b0;
            c_ebreak  <= 1'b0;
        end else begin
            c_valid   <= f_valid;
            c_illegal <= f_valid && !legal;
            c_ebreak  <= f_valid && ebreak_d;
        end
    end

    always_ff @(posedge clk) begin
        if (f_valid) begin
            c_fields   <= f_fields;
            c_ctrl     <= ctrl_d;
            c_imm_kind <= kind_d;
        end
    end

    // a rejected word must reach stage 3 with no side effects
    a_illegal_quiet: assert property (@(posedge clk) disable iff (!arst_n)
        f_valid && !legal |=> c_illegal && !(c_ctrl.reg_wen || c_ctrl.mem_read
            || c_ctrl.mem_write || c_ctrl.branch || c_ctrl.jump));

    a_flags_excl: assert property (@(posedge clk) disable iff (!arst_n)
        !(c_illegal && c_ebreak));

endmodule

/* design/rv_decode_cfg.svh */
`ifndef RV_DECODE_CFG_SVH
`define RV_DECODE_CFG_SVH

// instruction word width
`define RV_INST_W 32

// register and immediate width
`define RV_XLEN 64

// register file address width
`define RV_REG_AW 5

// shift amount width for rv64 shifts
`define RV_SHAMT_W 6

// the single legal ebreak encoding
`define RV_EBREAK_WORD 32'h0010_0073

`endif

/* design/rv_decode_top.sv */
`include "rv_decode_cfg.svh"

module rv_decode_top (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   inst_valid,
    input  logic [`RV_INST_W-1:0]  inst,
    output logic                   dec_valid,
    output rv_ctrl_pkg::dec_ctrl_t dec,
    output logic [`RV_XLEN-1:0]    imm,
    output logic                   illegal,
    output logic                   ebreak
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic       f_valid;
    rv_fields_t f_fields;
    logic       c_valid;
    rv_fields_t c_fields;
    dec_ctrl_t  c_ctrl;
    imm_kind_e  c_imm_kind;
    logic       c_illegal;
    logic       c_ebreak;

    rv_field_stage u_field (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .f_valid    (f_valid),
        .f_fields   (f_fields)
    );

    rv_ctrl_stage u_ctrl (
        .clk        (clk),
        .arst_n     (arst_n),
        .f_valid    (f_valid),
        .f_fields   (f_fields),
        .c_valid    (c_valid),
        .c_fields   (c_fields),
        .c_ctrl     (c_ctrl),
        .c_imm_kind (c_imm_kind),
        .c_illegal  (c_illegal),
        .c_ebreak   (c_ebreak)
    );

    rv_imm_stage u_imm (
        .clk        (clk),
        .arst_n     (arst_n),
        .c_valid    (c_valid),
        .c_fields   (c_fields),
        .c_ctrl     (c_ctrl),
        .c_imm_kind (c_imm_kind),
        .c_illegal  (c_illegal),
        .c_ebreak   (c_ebreak),
        .dec_valid  (dec_valid),
        .dec        (dec),
        .imm        (imm),
        .illegal    (illegal),
        .ebreak     (ebreak)
    );

endmodule

/* design/rv_field_stage.sv */
`include "rv_decode_cfg.svh"

module rv_field_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   inst_valid,
    input  logic [`RV_INST_W-1:0]  inst,
    output logic                   f_valid,
    output rv_isa_pkg::rv_fields_t f_fields
);

    import rv_isa_pkg::*;

    rv_fields_t fields_d;

    // fixed rv bit positions
    always_comb begin
        fields_d.raw    = inst;
        fields_d.opcode = rv_opcode_e'(inst[6:0]);
        fields_d.funct3 = inst[14:12];
        fields_d.funct7 = inst[31:25];
        fields_d.rd     = inst[11:7];
        fields_d.rs1    = inst[19:15];
        fields_d.rs2    = inst[24:20];
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            f_valid <= 1'b0;
        end else begin
            f_valid <= inst_valid;
        end
    end

    // payload only moves on a strobe
    always_ff @(posedge clk) begin
        if (inst_valid) begin
            f_fields <= fields_d;
        end
    end

endmodule

/* design/rv_imm_stage.sv */
`include "rv_decode_cfg.svh"

module rv_imm_stage (
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   c_valid,
    input  rv_isa_pkg::rv_fields_t c_fields,
    input  rv_ctrl_pkg::dec_ctrl_t c_ctrl,
    input  rv_ctrl_pkg::imm_kind_e c_imm_kind,
    input  logic                   c_illegal,
    input  logic                   c_ebreak,
    output logic                   dec_valid,
    output rv_ctrl_pkg::dec_ctrl_t dec,
    output logic [`RV_XLEN-1:0]    imm,
    output logic                   illegal,
    output logic                   ebreak
);

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    logic [`RV_INST_W-1:0] w;
    logic [`RV_XLEN-1:0]   imm_d;

    assign w = c_fields.raw;

    always_comb begin
        case (c_imm_kind)
            IMM_I:     imm_d = {{(`RV_XLEN-12){w[31]}}, w[31:20]};
            IMM_S:     imm_d = {{(`RV_XLEN-12){w[31]}}, w[31:25], w[11:7]};
            IMM_B:     imm_d = {{(`RV_XLEN-12){w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            IMM_U:     imm_d = {{(`RV_XLEN-32){w[31]}}, w[31:12], 12'b0};
            IMM_J:     imm_d = {{(`RV_XLEN-20){w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            IMM_SHAMT: imm_d = {{(`RV_XLEN-`RV_SHAMT_W){1'b0}}, w[20 +: `RV_SHAMT_W]};
            default:   imm_d = '0; // IMM_NONE
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid <= 1'b0;
            illegal   <= 1'b0;
            ebreak    <= 1'b0;
        end else begin
            dec_valid <= c_valid;
            illegal   <= c_valid && c_illegal;
            ebreak    <= c_valid && c_ebreak;
        end
    end

    always_ff @(posedge clk) begin
        if (c_valid) begin
            dec <= c_ctrl;
            imm <= imm_d;
        end
    end

    a_valid_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(dec_valid));

endmodule

/* design/rv_isa_pkg.sv */
`include "rv_decode_cfg.svh"

package rv_isa_pkg;

    // major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_LOAD      = 7'b0000011,
        OPC_OP_IMM    = 7'b0010011,
        OPC_AUIPC     = 7'b0010111,
        OPC_OP_IMM_32 = 7'b0011011,
        OPC_STORE     = 7'b0100011,
        OPC_OP        = 7'b0110011,
        OPC_LUI       = 7'b0110111,
        OPC_OP_32     = 7'b0111011,
        OPC_BRANCH    = 7'b1100011,
        OPC_JALR      = 7'b1100111,
        OPC_JAL       = 7'b1101111,
        OPC_SYSTEM    = 7'b1110011
    } rv_opcode_e;

    // funct3 of integer alu ops
    typedef enum logic [2:0] {
        F3_ADD  = 3'd0,
        F3_SLL  = 3'd1,
        F3_SLT  = 3'd2,
        F3_SLTU = 3'd3,
        F3_XOR  = 3'd4,
        F3_SR   = 3'd5, // srl / sra by funct7
        F3_OR   = 3'd6,
        F3_AND  = 3'd7
    } rv_alu_f3_e;

    // funct3 of the M extension subset
    typedef enum logic [2:0] {
        F3_MUL  = 3'd0,
        F3_DIV  = 3'd4,
        F3_DIVU = 3'd5,
        F3_REM  = 3'd6,
        F3_REMU = 3'd7
    } rv_mdu_f3_e;

    // funct3 of branches
    typedef enum logic [2:0] {
        F3_BEQ  = 3'd0,
        F3_BNE  = 3'd1,
        F3_BLT  = 3'd4,
        F3_BGE  = 3'd5,
        F3_BLTU = 3'd6,
        F3_BGEU = 3'd7
    } rv_br_f3_e;

    typedef struct packed {
        logic [`RV_INST_W-1:0] raw;    // whole word, kept for immediates
        rv_opcode_e            opcode;
        logic [2:0]            funct3;
        logic [6:0]            funct7;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
    } rv_fields_t;

endpackage

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
    --top-module tb_rv_decode -f sim.f -Mdir obj_dir -o tb_rv_decode

./obj_dir/tb_rv_decode | tee sim.log

if grep -q "Simulation PASSED" sim.log; then
    echo "run.sh: simulation passed"
    exit 0
fi
echo "run.sh: simulation did not pass, see sim.log"
exit 1

/* sim.f */
+incdir+design
design/rv_isa_pkg.sv
design/rv_ctrl_pkg.sv
design/rv_field_stage.sv
design/rv_ctrl_stage.sv
design/rv_imm_stage.sv
design/rv_decode_top.sv
verification/tb_rv_decode.sv

/* verification/tb_rv_decode.sv */
`include "rv_decode_cfg.svh"

module tb_rv_decode;
    timeunit 1ns;
    timeprecision 100ps;

    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;

    localparam int          N_CYCLES = 3000;
    localparam logic [31:0] M_OPC    = 32'h0000_007f;
    localparam logic [31:0] M_F3     = 32'h0000_707f;
    localparam logic [31:0] M_SH     = 32'hfc00_707f; // funct7[0] is shamt[5]
    localparam logic [31:0] M_F7     = 32'hfe00_707f;

    typedef struct packed {
        dec_ctrl_t   ctrl;
        logic [63:0] imm;
        logic        illegal;
        logic        ebreak;
        logic [31:0] due; // negedge count where the result shows up
    } expect_t;

    logic        clk;
    logic        arst_n;
    logic        inst_valid;
    logic [31:0] inst;
    logic        dec_valid;
    dec_ctrl_t   dec;
    logic [63:0] imm;
    logic        illegal;
    logic        ebreak;

    integer      seed;
    int          cyc;
    int          errors;
    int          checked;
    int          waited;
    logic [31:0] word;
    expect_t     exp_q[$];
    logic [31:0] tmpl_q[$];
    logic [31:0] mask_q[$];

    rv_decode_top dut0 (
        .clk        (clk),
        .arst_n     (arst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .dec_valid  (dec_valid),
        .dec        (dec),
        .imm        (imm),
        .illegal    (illegal),
        .ebreak     (ebreak)
    );

    always #2 clk = ~clk;

    function automatic alu_op_e std_alu_op(input logic [2:0] f3);
        case (f3)
            3'd0:    return ALU_ADD;
            3'd1:    return ALU_SLL;
            3'd2:    return ALU_SLT;
            3'd3:    return ALU_SLTU;
            3'd4:    return ALU_XOR;
            3'd5:    return ALU_SRL;
            3'd6:    return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    function automatic alu_op_e mdu_alu_op(input logic [2:0] f3);
        case (f3)
            3'd0:    return ALU_MUL;
            3'd4:    return ALU_DIV;
            3'd5:    return ALU_DIVU;
            3'd6:    return ALU_REM;
            default: return ALU_REMU;
        endcase
    endfunction

    task automatic add_combo(input logic [6:0] opc, input logic [2:0] f3,
                             input logic [6:0] f7, input logic [31:0] mask);
        tmpl_q.push_back({f7, 10'd0, f3, 5'd0, opc});
        mask_q.push_back(mask);
    endtask

    // legal opcode/funct3/funct7 combinations
    task automatic build_table();
        logic [2:0] f3;
        for (int f = 0; f < 8; f++) begin
            f3 = 3'(f);
            add_combo(OPC_OP, f3, 7'd0, M_F7);
            if (f == 0 || f == 5) begin
                add_combo(OPC_OP, f3, 7'd32, M_F7);
                add_combo(OPC_OP_32, f3, 7'd32, M_F7);
            end
            if (f == 0 || f == 1 || f == 5) add_combo(OPC_OP_32, f3, 7'd0, M_F7);
            if (f == 0 || f >= 4) begin
                add_combo(OPC_OP, f3, 7'd1, M_F7);
                add_combo(OPC_OP_32, f3, 7'd1, M_F7);
            end
            if (f != 1 && f != 5) add_combo(OPC_OP_IMM, f3, 7'd0, M_F3);
            if (f != 7) add_combo(OPC_LOAD, f3, 7'd0, M_F3);
            if (f < 4) add_combo(OPC_STORE, f3, 7'd0, M_F3);
            if (f != 2 && f != 3) add_combo(OPC_BRANCH, f3, 7'd0, M_F3);
        end
        add_combo(OPC_OP_IMM, 3'd1, 7'd0, M_SH);
        add_combo(OPC_OP_IMM, 3'd5, 7'd0, M_SH);
        add_combo(OPC_OP_IMM, 3'd5, 7'd32, M_SH);
        add_combo(OPC_OP_IMM_32, 3'd0, 7'd0, M_F3);
        add_combo(OPC_OP_IMM_32, 3'd1, 7'd0, M_F7);
        add_combo(OPC_OP_IMM_32, 3'd5, 7'd0, M_F7);
        add_combo(OPC_OP_IMM_32, 3'd5, 7'd32, M_F7);
        add_combo(OPC_JALR, 3'd0, 7'd0, M_F3);
        add_combo(OPC_JAL, 3'd0, 7'd0, M_OPC);
        add_combo(OPC_LUI, 3'd0, 7'd0, M_OPC);
        add_combo(OPC_AUIPC, 3'd0, 7'd0, M_OPC);
    endtask

    task automatic gen_inst(output logic [31:0] w);
        int unsigned pick;
        int unsigned idx;
        w    = $random(seed);
        pick = $unsigned($random(seed)) % 100;
        if (pick < 80) begin
            idx = $unsigned($random(seed)) % tmpl_q.size();
            w   = (w & ~mask_q[idx]) | (tmpl_q[idx] & mask_q[idx]);
        end else if (pick >= 95) begin
            w = `RV_EBREAK_WORD;
        end
    endtask

    // reference decode, straight from the encoding rules
    task automatic predict(input logic [31:0] w, input int due);
        expect_t    e;
        dec_ctrl_t  c;
        imm_kind_e  kind;
        logic [6:0] opc;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [6:0] hi;
        logic       ok;
        logic       ebr;
        opc   = w[6:0];
        f3    = w[14:12];
        f7    = w[31:25];
        c     = '0;
        c.rd  = w[11:7];
        c.rs1 = w[19:15];
        c.rs2 = w[24:20];
        kind  = IMM_NONE;
        ok    = 1'b1;
        ebr   = 1'b0;
        case (opc)
            OPC_OP, OPC_OP_32: begin
                c.reg_wen  = 1'b1;
                c.rs1_used = 1'b1;
                c.rs2_used = 1'b1;
                c.word_op  = (opc == OPC_OP_32);
                if (f7 == 7'd0) begin
                    c.alu_op = std_alu_op(f3);
                    ok = !c.word_op || f3 == 3'd0 || f3 == 3'd1 || f3 == 3'd5;
                end else if (f7 == 7'd32) begin
                    c.alu_op = (f3 == 3'd0) ? ALU_SUB : ALU_SRA;
                    ok = (f3 == 3'd0) || (f3 == 3'd5);
                end else if (f7 == 7'd1) begin
                    c.alu_op = mdu_alu_op(f3);
                    ok = (f3 == 3'd0) || f3[2];
                end else begin
                    ok = 1'b0;
                end
            end
            OPC_OP_IMM, OPC_OP_IMM_32: begin
                c.reg_wen  = 1'b1;
                c.rs1_used = 1'b1;
                c.alu_src  = SRC_IMM;
                c.word_op  = (opc == OPC_OP_IMM_32);
                c.alu_op   = std_alu_op(f3);
                kind       = IMM_I;
                if (f3 == 3'd1 || f3 == 3'd5) begin
                    kind = IMM_SHAMT;
                    hi   = c.word_op ? f7 : {f7[6:1], 1'b0};
                    ok   = (hi == 7'd0) || (hi == 7'd32 && f3 == 3'd5);
                    if (hi == 7'd32) c.alu_op = ALU_SRA;
                end else begin
                    ok = !c.word_op || f3 == 3'd0;
                end
            end
            OPC_LOAD: begin
                c.reg_wen      = 1'b1;
                c.rs1_used     = 1'b1;
                c.alu_src      = SRC_IMM;
                c.mem_read     = 1'b1;
                c.mem_size     = mem_size_e'(f3[1:0]);
                c.mem_unsigned = f3[2];
                kind           = IMM_I;
                ok             = (f3 != 3'd7);
            end
            OPC_STORE: begin
                c.rs1_used  = 1'b1;
                c.rs2_used  = 1'b1;
                c.alu_src   = SRC_IMM;
                c.mem_write = 1'b1;
                c.mem_size  = mem_size_e'(f3[1:0]);
                kind        = IMM_S;
                ok          = (f3 < 3'd4);
            end
            OPC_BRANCH: begin
                c.rs1_used = 1'b1;
                c.rs2_used = 1'b1;
                c.alu_src  = SRC_PC_IMM;
                c.branch   = 1'b1;
                kind       = IMM_B;
                case (f3)
                    3'd0:    c.br_cond = BR_EQ;
                    3'd1:    c.br_cond = BR_NE;
                    3'd4:    c.br_cond = BR_LT;
                    3'd5:    c.br_cond = BR_GE;
                    3'd6:    c.br_cond = BR_LTU;
                    3'd7:    c.br_cond = BR_GEU;
                    default: ok = 1'b0;
                endcase
            end
            OPC_JAL: begin
                c.reg_wen = 1'b1;
                c.alu_src = SRC_PC_FOUR;
                c.jump    = 1'b1;
                kind      = IMM_J;
            end
            OPC_JALR: begin
                c.reg_wen  = 1'b1;
                c.rs1_used = 1'b1;
                c.alu_src  = SRC_PC_FOUR;
                c.jump     = 1'b1;
                c.jalr     = 1'b1;
                kind       = IMM_I;
                ok         = (f3 == 3'd0);
            end
            OPC_LUI: begin
                c.reg_wen = 1'b1;
                c.rs1     = '0;
                c.alu_src = SRC_IMM;
                kind      = IMM_U;
            end
            OPC_AUIPC: begin
                c.reg_wen = 1'b1;
                c.alu_src = SRC_PC_IMM;
                kind      = IMM_U;
            end
            OPC_SYSTEM: begin
                ebr = (w == `RV_EBREAK_WORD);
                ok  = ebr;
            end
            default: ok = 1'b0;
        endcase
        if (!ok || ebr) begin
            c    = '0;
            kind = IMM_NONE;
        end
        e.ctrl    = c;
        e.illegal = !ok;
        e.ebreak  = ebr;
        e.due     = due;
        case (kind)
            IMM_I:     e.imm = {{52{w[31]}}, w[31:20]};
            IMM_S:     e.imm = {{52{w[31]}}, w[31:25], w[11:7]};
            IMM_B:     e.imm = {{51{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            IMM_U:     e.imm = {{32{w[31]}}, w[31:12], 12'h000};
            IMM_J:     e.imm = {{43{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            IMM_SHAMT: e.imm = {58'd0, w[25:20]};
            default:   e.imm = '0;
        endcase
        exp_q.push_back(e);
    endtask

    task automatic check_field(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        if (got !== want) begin
            errors++;
            $display("Mismatch %s: expected %h got %h", name, want, got);
        end
    endtask

    task automatic check_outputs();
        expect_t e;
        if (!dec_valid) begin
            if (exp_q.size() != 0 && int'(exp_q[0].due) <= cyc) begin
                e = exp_q.pop_front();
                errors++;
                $display("ERROR: no dec_valid pulse for the result due at cycle %0d", e.due);
            end
        end else if (exp_q.size() == 0) begin
            errors++;
            $display("ERROR: dec_valid pulse at cycle %0d with nothing in flight", cyc);
        end else begin
            e = exp_q.pop_front();
            checked++;
            check_field("dec_valid cycle", cyc, e.due);
            check_field("dec.rd", dec.rd, e.ctrl.rd);
            check_field("dec.rs1", dec.rs1, e.ctrl.rs1);
            check_field("dec.rs2", dec.rs2, e.ctrl.rs2);
            check_field("dec.reg_wen", dec.reg_wen, e.ctrl.reg_wen);
            check_field("dec.rs1_used", dec.rs1_used, e.ctrl.rs1_used);
            check_field("dec.rs2_used", dec.rs2_used, e.ctrl.rs2_used);
            check_field("dec.alu_op", dec.alu_op, e.ctrl.alu_op);
            check_field("dec.alu_src", dec.alu_src, e.ctrl.alu_src);
            check_field("dec.word_op", dec.word_op, e.ctrl.word_op);
            check_field("dec.mem_read", dec.mem_read, e.ctrl.mem_read);
            check_field("dec.mem_write", dec.mem_write, e.ctrl.mem_write);
            check_field("dec.mem_size", dec.mem_size, e.ctrl.mem_size);
            check_field("dec.mem_unsigned", dec.mem_unsigned, e.ctrl.mem_unsigned);
            check_field("dec.branch", dec.branch, e.ctrl.branch);
            check_field("dec.br_cond", dec.br_cond, e.ctrl.br_cond);
            check_field("dec.jump", dec.jump, e.ctrl.jump);
            check_field("dec.jalr", dec.jalr, e.ctrl.jalr);
            check_field("imm", imm, e.imm);
            check_field("illegal", illegal, e.illegal);
            check_field("ebreak", ebreak, e.ebreak);
        end
    endtask

    // outputs are sampled half a cycle after the rising edge
    task automatic next_cycle();
        @(negedge clk);
        cyc++;
        check_outputs();
    endtask

    initial begin
        clk        = 1'b0;
        arst_n     = 1'b0;
        inst_valid = 1'b0;
        inst       = '0;
        seed       = 32'ha8d47d5b;
        cyc        = 0;
        errors     = 0;
        checked    = 0;
        build_table();
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;

        repeat (3) begin // idle after reset
            @(negedge clk);
            check_field("dec_valid", dec_valid, 64'd0);
            check_field("illegal", illegal, 64'd0);
            check_field("ebreak", ebreak, 64'd0);
        end

        for (int n = 0; n < N_CYCLES; n++) begin
            next_cycle();
            inst_valid = (($random(seed) & 3) != 0);
            gen_inst(word);
            inst = word;
            if (inst_valid) predict(word, cyc + 3); // sampled, then two more edges
        end
        next_cycle(); // last strobe gets sampled first
        inst_valid = 1'b0;

        waited = 0;
        while (exp_q.size() != 0 && waited < 50) begin
            next_cycle();
            waited++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("ERROR: %0d results still pending after the drain timeout", exp_q.size());
        end

        $display("%0d results checked, %0d errors", checked, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule
